//--- rtl/sdram_ahb_params.svh
`ifndef SDRAM_AHB_PARAMS_SVH
`define SDRAM_AHB_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

// AHB address width in bits
`define SDRAM_AHB_ADDR_W 32

// AHB data width in bits
`define SDRAM_AHB_DATA_W 32

//////////////////////////////////////////////////////////////////////
// write buffer geometry
//////////////////////////////////////////////////////////////////////

// words held by one ping-pong line
`define SDRAM_AHB_LINE_WORDS 4

// width of the timeout exponent input
// a value t gives a flush after 2^t idle cycles
`define SDRAM_AHB_TIMER_W 4

`endif

//--- rtl/sdram_ahb_pkg.sv
`include "sdram_ahb_params.svh"

package sdram_ahb_pkg;

  // derived sizes
  localparam int BE_W       = `SDRAM_AHB_DATA_W / 8;
  localparam int LINE_W     = `SDRAM_AHB_LINE_WORDS * `SDRAM_AHB_DATA_W;
  localparam int LINE_BE_W  = LINE_W / 8;
  // byte offset bits inside a word and inside a line
  localparam int WORD_OFS_W = $clog2(BE_W);
  localparam int LINE_OFS_W = $clog2(LINE_BE_W);

  // AHB response, only OKAY is ever given
  localparam logic HRESP_OKAY = 1'b0;

  // AHB transfer type
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // AHB transfer size, up to the bus width
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_t;

  typedef logic [`SDRAM_AHB_ADDR_W-1:0]              addr_t;
  typedef logic [`SDRAM_AHB_DATA_W-1:0]              word_t;
  typedef logic [BE_W-1:0]                           be_t;
  typedef logic [LINE_W-1:0]                         line_t;
  typedef logic [LINE_BE_W-1:0]                      line_be_t;
  // line address, byte address without the line offset
  typedef logic [`SDRAM_AHB_ADDR_W-LINE_OFS_W-1:0]   tag_t;
  typedef logic [LINE_OFS_W-WORD_OFS_W-1:0]          word_idx_t;

endpackage : sdram_ahb_pkg

//--- rtl/sdram_ahb_front.sv
`timescale 1ns/1ps

module sdram_ahb_front
(
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSEL,
  input  logic                  HREADY,
  input  logic                  HWRITE,
  input  sdram_ahb_pkg::htrans_t HTRANS,
  input  sdram_ahb_pkg::hsize_t HSIZE,
  input  sdram_ahb_pkg::addr_t  HADDR,
  input  logic                  wr_ready_i,
  input  logic                  rd_ready_i,
  output logic                  HREADYOUT,
  output logic                  ahb_wr_o,
  output logic                  ahb_rd_o,
  output sdram_ahb_pkg::tag_t   ahb_tag_o,
  output logic                  beat_wr_o,
  output logic                  beat_rd_o,
  output sdram_ahb_pkg::addr_t  beat_addr_o,
  output sdram_ahb_pkg::be_t    beat_be_o
);
  import sdram_ahb_pkg::*;

  logic xfer;

  // byte lanes for a transfer of the given size at the given offset
  function automatic be_t gen_be(input hsize_t size, input logic [WORD_OFS_W-1:0] ofs);
    be_t be;
    case (size)
      HSIZE_BYTE : be = be_t'(1) << ofs;
      // half-words sit on an even byte
      HSIZE_HWORD: be = be_t'(3) << {ofs[WORD_OFS_W-1:1], 1'b0};
      default    : be = '1;
    endcase
    return be;
  endfunction : gen_be

  //////////////////////////////////////////////////////////////////////
  // address phase
  //////////////////////////////////////////////////////////////////////

  // only nonseq and seq start a transfer, busy and idle are ignored
  assign xfer      = HSEL & HREADY & ((HTRANS == HTRANS_NONSEQ) | (HTRANS == HTRANS_SEQ));
  assign ahb_wr_o  = xfer &  HWRITE;
  assign ahb_rd_o  = xfer & ~HWRITE;
  // line address, lets the write buffer spot a read hit early
  assign ahb_tag_o = HADDR[$bits(addr_t)-1:LINE_OFS_W];

  //////////////////////////////////////////////////////////////////////
  // data phase
  //////////////////////////////////////////////////////////////////////

  // beat strobes follow HREADY, so they stay up through wait states
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      beat_wr_o <= 1'b0;
      beat_rd_o <= 1'b0;
    end
    else if (HREADY)
    begin
      beat_wr_o <= ahb_wr_o;
      beat_rd_o <= ahb_rd_o;
    end
  end

  // address and lanes of the accepted transfer
  always_ff @(posedge HCLK)
  begin
    if (xfer)
    begin
      beat_addr_o <= HADDR;
      beat_be_o   <= gen_be(HSIZE, HADDR[WORD_OFS_W-1:0]);
    end
  end

  // a new read always waits for the scheduler, both paths must agree otherwise
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      HREADYOUT <= 1'b1;
    else
      HREADYOUT <= wr_ready_i & rd_ready_i & ~ahb_rd_o;
  end

  // a wait state belongs to exactly one open beat, a write or a read
  a_beat_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !HREADYOUT |-> (beat_wr_o != beat_rd_o));

endmodule : sdram_ahb_front

//--- rtl/sdram_ahb_write_buffer.sv
`timescale 1ns/1ps
`include "sdram_ahb_params.svh"

module sdram_ahb_write_buffer
(
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  sdram_ahb_pkg::word_t          HWDATA,
  input  logic                          ahb_wr_i,
  input  logic                          ahb_rd_i,
  input  sdram_ahb_pkg::tag_t           ahb_tag_i,
  input  logic                          beat_wr_i,
  input  logic                          beat_rd_i,
  input  sdram_ahb_pkg::addr_t          beat_addr_i,
  input  sdram_ahb_pkg::be_t            beat_be_i,
  input  logic [`SDRAM_AHB_TIMER_W-1:0] timeout_i,
  input  logic                          wrrdy_i,
  output logic                          wr_ready_o,
  output logic                          rd_hit_dirty_o,
  output logic                          wrreq_o,
  output sdram_ahb_pkg::addr_t          wradr_o,
  output sdram_ahb_pkg::line_t          wrd_o,
  output sdram_ahb_pkg::line_be_t       wrbe_o
);
  import sdram_ahb_pkg::*;

  // idle counter is wide enough for 2^(2^TIMER_W - 1) cycles
  localparam int TMR_W = (1 << `SDRAM_AHB_TIMER_W) - 1;

  line_t      line_q  [2];
  line_be_t   be_q    [2];
  tag_t       tag_q   [2];
  logic [1:0] dirty_q;
  logic       sel_q;
  logic       pend_q;
  logic       hand_q;
  logic [TMR_W-1:0] tmr_q;
  logic [TMR_W-1:0] tmo_limit;
  tag_t       beat_tag;
  word_idx_t  beat_idx;
  logic       wr_en;
  logic       act_dirty;
  tag_t       act_tag;
  logic       act_hit;
  logic       tmo_fire;
  logic       flush_req;
  logic       other_free;
  logic       flush_go;
  logic       pend_nx;

  assign beat_tag = beat_addr_i[$bits(addr_t)-1:LINE_OFS_W];
  assign beat_idx = beat_addr_i[LINE_OFS_W-1:WORD_OFS_W];

  //////////////////////////////////////////////////////////////////////
  // flush decision
  //////////////////////////////////////////////////////////////////////

  // a beat held back by a pending flush does not merge yet
  assign wr_en = beat_wr_i & ~pend_q;

  // active line as it will look after this edge
  assign act_dirty = dirty_q[sel_q] | wr_en;
  assign act_tag   = wr_en ? beat_tag : tag_q[sel_q];
  assign act_hit   = act_dirty & (ahb_tag_i == act_tag);

  // timeout of zero turns the idle flush off
  assign tmo_limit = (TMR_W'(1) << timeout_i) - 1'b1;
  assign tmo_fire  = (timeout_i != '0) & dirty_q[sel_q] & ~wr_en & (tmr_q == tmo_limit);

  // write miss, read of the active line, or idle timeout
  assign flush_req = (ahb_wr_i & act_dirty & ~act_hit) | (ahb_rd_i & act_hit) | tmo_fire;

  // other line is clean, or its flush is taken on this edge
  assign other_free = ~dirty_q[~sel_q] | (wrreq_o & wrrdy_i);
  assign flush_go   = (pend_q | flush_req) & other_free;
  assign pend_nx    = (pend_q | flush_req) & ~other_free;

  // stall the next data phase only if it carries a write
  assign wr_ready_o = ~(pend_nx & (ahb_wr_i | (beat_wr_i & pend_q)));

  // read beat line sits in a dirty or not yet accepted buffer
  assign rd_hit_dirty_o = beat_rd_i & ((dirty_q[0] & (tag_q[0] == beat_tag)) |
                                       (dirty_q[1] & (tag_q[1] == beat_tag)));

  //////////////////////////////////////////////////////////////////////
  // ping-pong lines
  //////////////////////////////////////////////////////////////////////

  // byte merge into the active line
  always_ff @(posedge HCLK)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (beat_be_i[b])
          line_q[sel_q][(int'(beat_idx) * BE_W + b) * 8 +: 8] <= HWDATA[b*8 +: 8];
      end
      tag_q[sel_q] <= beat_tag;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      be_q[0] <= '0;
      be_q[1] <= '0;
      dirty_q <= 2'b00;
      sel_q   <= 1'b0;
      pend_q  <= 1'b0;
      hand_q  <= 1'b0;
    end
    else
    begin
      // the line that becomes active starts empty
      if (flush_go)
        be_q[~sel_q] <= '0;
      if (wr_en)
        be_q[sel_q][int'(beat_idx)*BE_W +: BE_W] <=
          be_q[sel_q][int'(beat_idx)*BE_W +: BE_W] | beat_be_i;
      if (wr_en)
        dirty_q[sel_q] <= 1'b1;
      // flushed line stays dirty until the scheduler takes it
      if (wrreq_o && wrrdy_i)
        dirty_q[~sel_q] <= 1'b0;
      if (flush_go)
        sel_q <= ~sel_q;
      pend_q <= pend_nx;
      // copy one cycle later so the last merge of the old line is in
      hand_q <= flush_go;
    end
  end

  // idle cycles since the last write into a dirty active line
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      tmr_q <= '0;
    else if (wr_en || flush_go || !dirty_q[sel_q])
      tmr_q <= '0;
    else if (tmr_q != tmo_limit)
      tmr_q <= tmr_q + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // flush register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      wrreq_o <= 1'b0;
    else if (hand_q)
      wrreq_o <= 1'b1;
    else if (wrrdy_i)
      wrreq_o <= 1'b0;
  end

  always_ff @(posedge HCLK)
  begin
    if (hand_q)
    begin
      wradr_o <= {tag_q[~sel_q], {LINE_OFS_W{1'b0}}};
      wrd_o   <= line_q[~sel_q];
      wrbe_o  <= be_q[~sel_q];
    end
  end

  // request and payload hold until the scheduler takes them
  a_wrreq_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wrreq_o && !wrrdy_i |=> wrreq_o && $stable(wradr_o) && $stable(wrd_o) && $stable(wrbe_o));

endmodule : sdram_ahb_write_buffer

//--- rtl/sdram_ahb_read_path.sv
`timescale 1ns/1ps

module sdram_ahb_read_path
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 beat_rd_i,
  input  sdram_ahb_pkg::addr_t beat_addr_i,
  input  logic                 rd_hit_dirty_i,
  input  logic                 rdrdy_i,
  input  sdram_ahb_pkg::word_t rdq_i,
  input  logic                 rdqvalid_i,
  output logic                 rd_ready_o,
  output sdram_ahb_pkg::word_t HRDATA,
  output logic                 rdreq_o,
  output sdram_ahb_pkg::addr_t rdadr_o,
  output logic                 wbr_o
);
  import sdram_ahb_pkg::*;

  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT} rd_state_t;

  rd_state_t rd_state;
  addr_t     adr_q;
  logic      wbr_q;
  // HRDATA was loaded on the last edge, the beat ends now
  logic      done_q;
  logic      start;
  addr_t     adr_aligned;

  // the last cycle of a finished read must not start it again
  assign start       = (rd_state == RD_IDLE) & beat_rd_i & ~done_q;
  assign adr_aligned = {beat_addr_i[$bits(addr_t)-1:WORD_OFS_W], {WORD_OFS_W{1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // scheduler request
  //////////////////////////////////////////////////////////////////////

  // first request cycle comes straight from the beat, later ones from the copy
  assign rdreq_o = start | (rd_state == RD_REQ);
  assign rdadr_o = start ? adr_aligned : adr_q;
  assign wbr_o   = rdreq_o & (start ? rd_hit_dirty_i : wbr_q);

  // next HREADYOUT from the read side
  assign rd_ready_o = ((rd_state == RD_IDLE) & ~start) | ((rd_state == RD_WAIT) & rdqvalid_i);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      rd_state <= RD_IDLE;
      done_q   <= 1'b0;
    end
    else
    begin
      done_q <= (rd_state == RD_WAIT) & rdqvalid_i;
      case (rd_state)
        RD_IDLE: if (start) rd_state <= rdrdy_i ? RD_WAIT : RD_REQ;
        RD_REQ : if (rdrdy_i) rd_state <= RD_WAIT;
        RD_WAIT: if (rdqvalid_i) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // hold address and flag while the scheduler is busy
  always_ff @(posedge HCLK)
  begin
    if (start)
    begin
      adr_q <= adr_aligned;
      wbr_q <= rd_hit_dirty_i;
    end
  end

  // read word, one strobe and no back-pressure
  always_ff @(posedge HCLK)
  begin
    if ((rd_state == RD_WAIT) && rdqvalid_i)
      HRDATA <= rdq_i;
  end

  // request, address and flag hold until the scheduler takes them
  a_rdreq_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    rdreq_o && !rdrdy_i |=> rdreq_o && $stable(rdadr_o) && $stable(wbr_o));

endmodule : sdram_ahb_read_path

//--- rtl/sdram_ahb_if.sv
`timescale 1ns/1ps
`include "sdram_ahb_params.svh"

module sdram_ahb_if
(
  // AHB3-Lite slave
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          HSEL,
  input  sdram_ahb_pkg::htrans_t        HTRANS,
  input  sdram_ahb_pkg::hsize_t         HSIZE,
  input  logic                          HWRITE,
  input  sdram_ahb_pkg::addr_t          HADDR,
  input  sdram_ahb_pkg::word_t          HWDATA,
  input  logic                          HREADY,
  output logic                          HREADYOUT,
  output logic                          HRESP,
  output sdram_ahb_pkg::word_t          HRDATA,
  // idle flush exponent
  input  logic [`SDRAM_AHB_TIMER_W-1:0] timeout_i,
  // scheduler write side
  output logic                          wrreq_o,
  input  logic                          wrrdy_i,
  output sdram_ahb_pkg::addr_t          wradr_o,
  output sdram_ahb_pkg::line_t          wrd_o,
  output sdram_ahb_pkg::line_be_t       wrbe_o,
  // scheduler read side
  output logic                          rdreq_o,
  input  logic                          rdrdy_i,
  output sdram_ahb_pkg::addr_t          rdadr_o,
  output logic                          wbr_o,
  input  sdram_ahb_pkg::word_t          rdq_i,
  input  logic                          rdqvalid_i
);
  import sdram_ahb_pkg::*;

  logic  ahb_wr, ahb_rd;
  tag_t  ahb_tag;
  logic  beat_wr, beat_rd;
  addr_t beat_addr;
  be_t   beat_be;
  logic  wr_ready, rd_ready;
  logic  rd_hit_dirty;

  // errors are never signalled
  assign HRESP = HRESP_OKAY;

  sdram_ahb_front u_front (
    .HCLK, .HRESETn, .HSEL, .HREADY, .HWRITE, .HTRANS, .HSIZE, .HADDR,
    .wr_ready_i  (wr_ready),
    .rd_ready_i  (rd_ready),
    .HREADYOUT,
    .ahb_wr_o    (ahb_wr),
    .ahb_rd_o    (ahb_rd),
    .ahb_tag_o   (ahb_tag),
    .beat_wr_o   (beat_wr),
    .beat_rd_o   (beat_rd),
    .beat_addr_o (beat_addr),
    .beat_be_o   (beat_be)
  );

  // writes merge here, reads only look at the tags
  sdram_ahb_write_buffer u_write_buffer (
    .HCLK, .HRESETn, .HWDATA,
    .ahb_wr_i       (ahb_wr),
    .ahb_rd_i       (ahb_rd),
    .ahb_tag_i      (ahb_tag),
    .beat_wr_i      (beat_wr),
    .beat_rd_i      (beat_rd),
    .beat_addr_i    (beat_addr),
    .beat_be_i      (beat_be),
    .timeout_i, .wrrdy_i,
    .wr_ready_o     (wr_ready),
    .rd_hit_dirty_o (rd_hit_dirty),
    .wrreq_o, .wradr_o, .wrd_o, .wrbe_o
  );

  sdram_ahb_read_path u_read_path (
    .HCLK, .HRESETn,
    .beat_rd_i      (beat_rd),
    .beat_addr_i    (beat_addr),
    .rd_hit_dirty_i (rd_hit_dirty),
    .rdrdy_i, .rdq_i, .rdqvalid_i,
    .rd_ready_o     (rd_ready),
    .HRDATA, .rdreq_o, .rdadr_o, .wbr_o
  );

endmodule : sdram_ahb_if

//--- verification/sdram_mem_model.sv
`timescale 1ns/1ps

module sdram_mem_model
(
  input  logic                    HCLK,
  input  logic                    HRESETn,
  // extra cycles before write ready
  input  logic [3:0]              wr_delay_i,
  input  logic                    wrreq_i,
  output logic                    wrrdy_o,
  input  sdram_ahb_pkg::addr_t    wradr_i,
  input  sdram_ahb_pkg::line_t    wrd_i,
  input  sdram_ahb_pkg::line_be_t wrbe_i,
  input  logic                    rdreq_i,
  output logic                    rdrdy_o,
  input  sdram_ahb_pkg::addr_t    rdadr_i,
  input  logic                    wbr_i,
  output sdram_ahb_pkg::word_t    rdq_o,
  output logic                    rdqvalid_o
);
  import sdram_ahb_pkg::*;

  localparam int ENTRIES = 16;

  // small associative store, one line per entry
  tag_t       mtag   [ENTRIES];
  line_t      mline  [ENTRIES];
  logic       mvalid [ENTRIES];
  logic [3:0] wcnt;
  logic [1:0] ret_cnt;
  addr_t      ret_adr;

  // contents of a word never written
  function automatic word_t init_pattern(input addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  function automatic int find_entry(input tag_t t);
    for (int i = 0; i < ENTRIES; i++)
    begin
      if (mvalid[i] && mtag[i] == t)
        return i;
    end
    return -1;
  endfunction

  function automatic word_t read_word(input addr_t a);
    int idx;
    idx = find_entry(a[$bits(addr_t)-1:LINE_OFS_W]);
    if (idx < 0)
      return init_pattern({a[$bits(addr_t)-1:WORD_OFS_W], {WORD_OFS_W{1'b0}}});
    return mline[idx][int'(a[LINE_OFS_W-1:WORD_OFS_W]) * 32 +: 32];
  endfunction

  // byte enabled line write, a new entry starts from the pattern
  task automatic store_line(input addr_t a, input line_t d, input line_be_t be);
    int   idx;
    tag_t t;
    t   = a[$bits(addr_t)-1:LINE_OFS_W];
    idx = find_entry(t);
    if (idx < 0)
    begin
      idx = 0;
      for (int i = ENTRIES - 1; i >= 0; i--)
      begin
        if (!mvalid[i])
          idx = i;
      end
      mvalid[idx] = 1'b1;
      mtag[idx]   = t;
      for (int w = 0; w < 4; w++)
        mline[idx][w*32 +: 32] = init_pattern({t, LINE_OFS_W'(w * 4)});
    end
    for (int b = 0; b < LINE_BE_W; b++)
    begin
      if (be[b])
        mline[idx][b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      wrrdy_o    <= 1'b0;
      wcnt       <= '0;
      rdrdy_o    <= 1'b0;
      rdqvalid_o <= 1'b0;
      rdq_o      <= '0;
      ret_cnt    <= '0;
      ret_adr    <= '0;
      for (int i = 0; i < ENTRIES; i++)
        mvalid[i] = 1'b0;
    end
    else
    begin
      // write side, ready one cycle after request plus the delay
      if (wrreq_i && wrrdy_o)
      begin
        store_line(wradr_i, wrd_i, wrbe_i);
        wrrdy_o <= 1'b0;
        wcnt    <= '0;
      end
      else if (wrreq_i)
      begin
        if (wcnt == wr_delay_i)
          wrrdy_o <= 1'b1;
        else
          wcnt <= wcnt + 1'b1;
      end
      // a wbr read waits while a write is outstanding
      rdrdy_o <= rdreq_i && !rdrdy_o && ret_cnt == 0 && !(wbr_i && wrreq_i);
      if (rdreq_i && rdrdy_o)
      begin
        ret_adr <= rdadr_i;
        ret_cnt <= 2'd3;
      end
      // data is looked up on return so earlier writes are in
      rdqvalid_o <= 1'b0;
      if (ret_cnt != 0)
      begin
        ret_cnt <= ret_cnt - 1'b1;
        if (ret_cnt == 1)
        begin
          rdqvalid_o <= 1'b1;
          rdq_o      <= read_word(ret_adr);
        end
      end
    end
  end

endmodule : sdram_mem_model

//--- verification/tb_sdram_ahb_if.sv
`timescale 1ns/1ps
`include "sdram_ahb_params.svh"

module tb_sdram_ahb_if;
  import sdram_ahb_pkg::*;

  logic     HCLK;
  logic     HRESETn;
  logic     HSEL;
  logic     HWRITE;
  htrans_t  HTRANS;
  hsize_t   HSIZE;
  addr_t    HADDR;
  word_t    HWDATA;
  logic     HREADY;
  logic     HREADYOUT;
  logic     HRESP;
  word_t    HRDATA;
  logic [`SDRAM_AHB_TIMER_W-1:0] timeout;
  logic     wrreq, wrrdy, rdreq, rdrdy, wbr, rdqvalid;
  addr_t    wradr, rdadr;
  line_t    wrd;
  line_be_t wrbe;
  word_t    rdq;
  logic [3:0] wr_delay;

  int       errors;
  int       tests;
  int       stalls;
  logic     last_wbr;
  addr_t    last_rdadr;
  word_t    rnd_state;
  // accepted line writes, in order
  addr_t    wq_adr  [$];
  line_t    wq_line [$];
  line_be_t wq_be   [$];
  // line left in the buffer by the merge test
  line_t    left_line;
  line_be_t left_be;

  // single slave, so HREADY is our own HREADYOUT
  assign HREADY = HREADYOUT;

  always #4 HCLK = ~HCLK;

  sdram_ahb_if UUT (
    .HCLK, .HRESETn, .HSEL, .HTRANS, .HSIZE, .HWRITE, .HADDR, .HWDATA, .HREADY,
    .HREADYOUT, .HRESP, .HRDATA,
    .timeout_i (timeout),
    .wrreq_o (wrreq), .wrrdy_i (wrrdy), .wradr_o (wradr), .wrd_o (wrd), .wrbe_o (wrbe),
    .rdreq_o (rdreq), .rdrdy_i (rdrdy), .rdadr_o (rdadr), .wbr_o (wbr),
    .rdq_i (rdq), .rdqvalid_i (rdqvalid)
  );

  sdram_mem_model u_mem (
    .HCLK, .HRESETn,
    .wr_delay_i (wr_delay),
    .wrreq_i (wrreq), .wrrdy_o (wrrdy), .wradr_i (wradr), .wrd_i (wrd), .wrbe_i (wrbe),
    .rdreq_i (rdreq), .rdrdy_o (rdrdy), .rdadr_i (rdadr), .wbr_i (wbr),
    .rdq_o (rdq), .rdqvalid_o (rdqvalid)
  );

  // record scheduler handshakes
  always @(posedge HCLK)
  begin
    if (HRESETn && wrreq && wrrdy)
    begin
      wq_adr.push_back(wradr);
      wq_line.push_back(wrd);
      wq_be.push_back(wrbe);
    end
    if (HRESETn && rdreq && rdrdy)
    begin
      last_wbr   = wbr;
      last_rdadr = rdadr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers and compare tasks
  //////////////////////////////////////////////////////////////////////

  function automatic word_t xorshift();
    word_t x;
    x = rnd_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rnd_state = x;
    return x;
  endfunction

  // expected contents of an unwritten word
  function automatic word_t init_pattern(input addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  // AHB byte lanes for size and address
  function automatic be_t lane_be(input hsize_t size, input addr_t a);
    case (size)
      HSIZE_BYTE : return be_t'(1) << a[1:0];
      HSIZE_HWORD: return a[1] ? 4'b1100 : 4'b0011;
      default    : return 4'b1111;
    endcase
  endfunction

  task automatic merge_exp(inout line_t l, inout line_be_t b, input addr_t a,
                           input hsize_t size, input word_t d);
    be_t be;
    int  w;
    be = lane_be(size, a);
    w  = int'(a[3:2]);
    for (int k = 0; k < 4; k++)
    begin
      if (be[k])
      begin
        l[(w*4 + k)*8 +: 8] = d[k*8 +: 8];
        b[w*4 + k]          = 1'b1;
      end
    end
  endtask

  // only enabled bytes carry meaning
  function automatic line_t mask_line(input line_t l, input line_be_t b);
    line_t m;
    for (int k = 0; k < LINE_BE_W; k++)
      m[k*8 +: 8] = b[k] ? l[k*8 +: 8] : 8'h00;
    return m;
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_line(input string name, input line_t got, input line_t exp);
    if (got !== exp)
    begin
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_be(input string name, input line_be_t got, input line_be_t exp);
    if (got !== exp)
    begin
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AHB driver
  //////////////////////////////////////////////////////////////////////

  // finish the current phase, back at 1 ns after the edge
  task automatic wait_ready();
    int n;
    n = 0;
    @(negedge HCLK);
    while (!HREADYOUT && n < 200)
    begin
      stalls++;
      n++;
      @(negedge HCLK);
    end
    if (!HREADYOUT)
    begin
      $display("timeout at %0t: HREADYOUT stayed low for 200 cycles", $time);
      errors++;
    end
    @(posedge HCLK);
    #1;
  endtask

  task automatic ahb_write(input addr_t a, input hsize_t size, input word_t d);
    HSEL   = 1'b1;
    HWRITE = 1'b1;
    HTRANS = HTRANS_NONSEQ;
    HSIZE  = size;
    HADDR  = a;
    wait_ready();
    HSEL   = 1'b0;
    HTRANS = HTRANS_IDLE;
    HWDATA = d;
    wait_ready();
  endtask

  task automatic ahb_read(input addr_t a, output word_t d);
    HSEL   = 1'b1;
    HWRITE = 1'b0;
    HTRANS = HTRANS_NONSEQ;
    HSIZE  = HSIZE_WORD;
    HADDR  = a;
    wait_ready();
    HSEL   = 1'b0;
    HTRANS = HTRANS_IDLE;
    wait_ready();
    d = HRDATA;
  endtask

  // one write with fresh data, folded into the expected line
  task automatic write_tracked(inout line_t l, inout line_be_t b, input addr_t a,
                               input hsize_t size);
    word_t d;
    d = xorshift();
    ahb_write(a, size, d);
    merge_exp(l, b, a, size, d);
  endtask

  task automatic wait_flushes(input int n, input int limit);
    int c;
    c = 0;
    while (wq_adr.size() < n && c < limit)
    begin
      @(posedge HCLK);
      #1;
      c++;
    end
    if (wq_adr.size() < n)
    begin
      $display("timeout at %0t: expected %0d line writes within %0d cycles, saw %0d",
               $time, n, limit, wq_adr.size());
      errors++;
    end
  endtask

  // oldest line write against the expected line
  task automatic check_flush(input addr_t a, input line_t l, input line_be_t b);
    if (wq_adr.size() == 0)
    begin
      $display("no line write reached the scheduler by %0t", $time);
      errors++;
    end
    else
    begin
      compare_word("wradr_o", wq_adr.pop_front(), a);
      compare_line("wrd_o", mask_line(wq_line.pop_front(), b), mask_line(l, b));
      compare_be("wrbe_o", wq_be.pop_front(), b);
    end
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    $display("test %-12s %s", name, (errors == err_before) ? "ok" : "had errors");
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e;
    e = errors;
    compare_word("HREADYOUT", word_t'(HREADYOUT), 1);
    compare_word("HRESP", word_t'(HRESP), 0);
    compare_word("wrreq_o", word_t'(wrreq), 0);
    compare_word("rdreq_o", word_t'(rdreq), 0);
    report("reset", e);
  endtask

  task automatic test_merge();
    int       e;
    line_t    el;
    line_be_t eb;
    e  = errors;
    el = '0;
    eb = '0;
    write_tracked(el, eb, 32'h1041, HSIZE_BYTE);
    write_tracked(el, eb, 32'h1046, HSIZE_HWORD);
    write_tracked(el, eb, 32'h1048, HSIZE_WORD);
    write_tracked(el, eb, 32'h1040, HSIZE_BYTE);
    write_tracked(el, eb, 32'h1048, HSIZE_HWORD);
    // miss to another line pushes the first one out
    left_line = '0;
    left_be   = '0;
    write_tracked(left_line, left_be, 32'h2004, HSIZE_WORD);
    wait_flushes(1, 200);
    check_flush(32'h1040, el, eb);
    report("merge", e);
  endtask

  task automatic test_timeout();
    int       e;
    line_t    el;
    line_be_t eb;
    e  = errors;
    el = '0;
    eb = '0;
    // the line left by the merge test goes first
    timeout = 3;
    wait_flushes(1, 50);
    check_flush(32'h2000, left_line, left_be);
    write_tracked(el, eb, 32'h300C, HSIZE_WORD);
    wait_flushes(1, 50);
    check_flush(32'h3000, el, eb);
    timeout = 0;
    report("timeout", e);
  endtask

  task automatic test_read_hit();
    int       e;
    line_t    el;
    line_be_t eb;
    word_t    got;
    e  = errors;
    el = '0;
    eb = '0;
    write_tracked(el, eb, 32'h4004, HSIZE_WORD);
    write_tracked(el, eb, 32'h4004, HSIZE_BYTE);
    ahb_read(32'h4004, got);
    compare_word("HRDATA", got, el[63:32]);
    compare_word("rdadr_o", last_rdadr, 32'h4004);
    compare_word("wbr_o", word_t'(last_wbr), 1);
    // the read also flushed the line
    wait_flushes(1, 200);
    check_flush(32'h4000, el, eb);
    report("read_hit", e);
  endtask

  task automatic test_read_miss();
    int    e;
    word_t got;
    e = errors;
    ahb_read(32'h5008, got);
    compare_word("HRDATA", got, init_pattern(32'h5008));
    compare_word("rdadr_o", last_rdadr, 32'h5008);
    compare_word("wbr_o", word_t'(last_wbr), 0);
    compare_word("HRESP", word_t'(HRESP), 0);
    report("read_miss", e);
  endtask

  task automatic test_stall();
    int    e;
    int    s0;
    word_t d [4];
    addr_t a [4];
    e  = errors;
    s0 = stalls;
    wr_delay = 4'd6;
    for (int i = 0; i < 4; i++)
    begin
      a[i] = 32'h6000 + i * 32'h100;
      d[i] = xorshift();
      ahb_write(a[i], HSIZE_WORD, d[i]);
    end
    wait_flushes(3, 200);
    for (int i = 0; i < 3; i++)
      check_flush(a[i], {96'h0, d[i]}, 16'h000F);
    if (stalls == s0)
    begin
      $display("no wait states seen while a flush was pending");
      errors++;
    end
    wr_delay = 4'd0;
    report("stall", e);
  endtask

  initial
  begin
    HCLK       = 1'b0;
    HRESETn    = 1'b0;
    HSEL       = 1'b0;
    HWRITE     = 1'b0;
    HTRANS     = HTRANS_IDLE;
    HSIZE      = HSIZE_WORD;
    HADDR      = '0;
    HWDATA     = '0;
    timeout    = '0;
    wr_delay   = '0;
    errors     = 0;
    tests      = 0;
    stalls     = 0;
    last_wbr   = 1'b0;
    last_rdadr = '0;
    rnd_state  = 32'd48;
    repeat (3) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    test_reset();
    test_merge();
    test_timeout();
    test_read_hit();
    test_read_miss();
    test_stall();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule : tb_sdram_ahb_if

//--- list.f
+incdir+rtl
rtl/sdram_ahb_pkg.sv
rtl/sdram_ahb_front.sv
rtl/sdram_ahb_write_buffer.sv
rtl/sdram_ahb_read_path.sv
rtl/sdram_ahb_if.sv
verification/sdram_mem_model.sv
verification/tb_sdram_ahb_if.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdram_ahb_if
FILELIST  ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
